//--- source/idPkg.sv
package idPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// codes as seen by the EX stage
	// andi and ori get codes apart from and/or
	typedef enum logic [5:0] {
		ADD = 6'd0, ADDI = 6'd1, ADDIU = 6'd2, ANDI = 6'd3,
		AND = 6'd4, ORI = 6'd7, LUI = 6'd8, J = 6'd14,
		NOR = 6'd15, OR = 6'd16, SLL = 6'd19, SLLV = 6'd20,
		SLT = 6'd21, SRA = 6'd25, SRAV = 6'd26, SRL = 6'd27,
		SRLV = 6'd28, SUB = 6'd29, SUBU = 6'd30, XOR = 6'd31,
		XORI = 6'd32, LB = 6'd33, BEQ = 6'd34, BGEZ = 6'd35,
		BGTZ = 6'd37, BLEZ = 6'd38, BLTZ = 6'd39, BNE = 6'd41,
		LBU = 6'd42, LH = 6'd43, LHU = 6'd44, SB = 6'd47,
		SH = 6'd48, SW = 6'd49, ADDU = 6'd55, LW = 6'd61,
		JR = 6'd62, SLTU = 6'd63
	} aluOp_t;

	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_REGIMM = 6'h01;
	localparam opcode_t OP_J = 6'h02;
	localparam opcode_t OP_JAL = 6'h03;
	localparam opcode_t OP_BEQ = 6'h04;
	localparam opcode_t OP_BNE = 6'h05;
	localparam opcode_t OP_BLEZ = 6'h06;
	localparam opcode_t OP_BGTZ = 6'h07;
	localparam opcode_t OP_ADDI = 6'h08;
	localparam opcode_t OP_ADDIU = 6'h09;
	localparam opcode_t OP_SLTI = 6'h0a;
	localparam opcode_t OP_SLTIU = 6'h0b;
	localparam opcode_t OP_ANDI = 6'h0c;
	localparam opcode_t OP_ORI = 6'h0d;
	localparam opcode_t OP_XORI = 6'h0e;
	localparam opcode_t OP_LUI = 6'h0f;
	localparam opcode_t OP_LB = 6'h20;
	localparam opcode_t OP_LH = 6'h21;
	localparam opcode_t OP_LW = 6'h23;
	localparam opcode_t OP_LBU = 6'h24;
	localparam opcode_t OP_LHU = 6'h25;
	localparam opcode_t OP_SB = 6'h28;
	localparam opcode_t OP_SH = 6'h29;
	localparam opcode_t OP_SW = 6'h2b;

	localparam funct_t FN_SLL = 6'h00;
	localparam funct_t FN_SRL = 6'h02;
	localparam funct_t FN_SRA = 6'h03;
	localparam funct_t FN_SLLV = 6'h04;
	localparam funct_t FN_SRLV = 6'h06;
	localparam funct_t FN_SRAV = 6'h07;
	localparam funct_t FN_JR = 6'h08;
	localparam funct_t FN_JALR = 6'h09;
	localparam funct_t FN_SYSCALL = 6'h0c;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR = 6'h25;
	localparam funct_t FN_XOR = 6'h26;
	localparam funct_t FN_NOR = 6'h27;
	localparam funct_t FN_SLT = 6'h2a;
	localparam funct_t FN_SLTU = 6'h2b;

	// rt field selects the REGIMM branch
	localparam regAddr_t RT_BLTZ = 5'h00;
	localparam regAddr_t RT_BGEZ = 5'h01;
	localparam regAddr_t RT_BLTZAL = 5'h10;
	localparam regAddr_t RT_BGEZAL = 5'h11;

	localparam regAddr_t LINK_REG = 5'd31;
	localparam regAddr_t SYSCALL_REG = 5'd2;
	localparam word_t LINK_OFFSET = 32'd4;

endpackage

//--- source/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
	import idPkg::*;

	logic regDst;
	logic link;
	logic jump;
	logic branch;
	logic memRead;
	logic memWrite;
	logic memToReg;
	logic aluSrc;
	logic regWrite;
	logic jumpReg;
	logic syscall;
	logic illegal;
	aluOp_t aluOp;

	modport decoder (
		output regDst, link, jump, branch, memRead, memWrite, memToReg,
		output aluSrc, regWrite, jumpReg, syscall, illegal, aluOp
	);

	modport pipe (
		input regDst, link, jump, branch, memRead, memWrite, memToReg,
		input aluSrc, regWrite, jumpReg, syscall, illegal, aluOp
	);

endinterface

//--- source/regReadIf.sv
`timescale 1ns/1ps

interface regReadIf;
	import idPkg::*;

	regAddr_t rsAddr;
	regAddr_t rtAddr;
	regAddr_t destAddr;
	word_t rsData;
	word_t rtData;
	word_t destData;
	// syscall code register
	word_t sysData;

	modport file (
		input rsAddr, rtAddr, destAddr,
		output rsData, rtData, destData, sysData
	);

	modport reader (input rsData, rtData);

	modport pipe (
		output destAddr,
		input rsData, rtData, destData, sysData
	);

endinterface

//--- source/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
	input idPkg::word_t instr,
	ctrlIf.decoder ctrl
);
	import idPkg::*;

	opcode_t opcode;
	funct_t funct;
	regAddr_t rtField;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rtField = instr[20:16];

	always_comb begin
		ctrl.regDst = 1'b0;
		ctrl.link = 1'b0;
		ctrl.jump = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.aluSrc = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.jumpReg = 1'b0;
		ctrl.syscall = 1'b0;
		ctrl.illegal = 1'b0;
		ctrl.aluOp = ADD;
		case (opcode)
			OP_SPECIAL: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					FN_SLL: ctrl.aluOp = SLL;
					FN_SRL: ctrl.aluOp = SRL;
					FN_SRA: ctrl.aluOp = SRA;
					FN_SLLV: ctrl.aluOp = SLLV;
					FN_SRLV: ctrl.aluOp = SRLV;
					FN_SRAV: ctrl.aluOp = SRAV;
					FN_ADD: ctrl.aluOp = ADD;
					FN_ADDU: ctrl.aluOp = ADDU;
					FN_SUB: ctrl.aluOp = SUB;
					FN_SUBU: ctrl.aluOp = SUBU;
					FN_AND: ctrl.aluOp = AND;
					FN_OR: ctrl.aluOp = OR;
					FN_XOR: ctrl.aluOp = XOR;
					FN_NOR: ctrl.aluOp = NOR;
					FN_SLT: ctrl.aluOp = SLT;
					FN_SLTU: ctrl.aluOp = SLTU;
					FN_JR: begin
						ctrl.regDst = 1'b0;
						ctrl.regWrite = 1'b0;
						ctrl.jumpReg = 1'b1;
						ctrl.aluOp = JR;
					end
					FN_JALR: begin
						// link goes to r31, not rd
						ctrl.regDst = 1'b0;
						ctrl.link = 1'b1;
						ctrl.jumpReg = 1'b1;
						ctrl.aluSrc = 1'b1;
						ctrl.aluOp = ADDI;
					end
					FN_SYSCALL: begin
						ctrl.regDst = 1'b0;
						ctrl.syscall = 1'b1;
						ctrl.aluSrc = 1'b1;
						ctrl.aluOp = ADDI;
					end
					default: begin
						ctrl.regDst = 1'b0;
						ctrl.regWrite = 1'b0;
						ctrl.illegal = 1'b1;
					end
				endcase
			end
			OP_REGIMM: begin
				ctrl.branch = 1'b1;
				case (rtField)
					RT_BLTZ: ctrl.aluOp = BLTZ;
					RT_BGEZ: ctrl.aluOp = BGEZ;
					RT_BLTZAL, RT_BGEZAL: begin
						ctrl.link = 1'b1;
						ctrl.aluSrc = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = ADDI;
					end
					default: begin
						ctrl.branch = 1'b0;
						ctrl.illegal = 1'b1;
					end
				endcase
			end
			OP_J: begin
				ctrl.jump = 1'b1;
				ctrl.aluOp = J;
			end
			OP_JAL: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = ADDI;
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
				ctrl.branch = 1'b1;
				case (opcode)
					OP_BEQ: ctrl.aluOp = BEQ;
					OP_BNE: ctrl.aluOp = BNE;
					OP_BLEZ: ctrl.aluOp = BLEZ;
					OP_BGTZ: ctrl.aluOp = BGTZ;
				endcase
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				case (opcode)
					OP_ADDI: ctrl.aluOp = ADDI;
					OP_ADDIU: ctrl.aluOp = ADDIU;
					OP_SLTI: ctrl.aluOp = SLT;
					OP_SLTIU: ctrl.aluOp = SLTU;
					OP_ANDI: ctrl.aluOp = ANDI;
					OP_ORI: ctrl.aluOp = ORI;
					OP_XORI: ctrl.aluOp = XORI;
					OP_LUI: ctrl.aluOp = LUI;
				endcase
			end
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				case (opcode)
					OP_LB: ctrl.aluOp = LB;
					OP_LH: ctrl.aluOp = LH;
					OP_LW: ctrl.aluOp = LW;
					OP_LBU: ctrl.aluOp = LBU;
					OP_LHU: ctrl.aluOp = LHU;
				endcase
			end
			OP_SB, OP_SH, OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				case (opcode)
					OP_SB: ctrl.aluOp = SB;
					OP_SH: ctrl.aluOp = SH;
					OP_SW: ctrl.aluOp = SW;
				endcase
			end
			default: ctrl.illegal = 1'b1;
		endcase
	end

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic CLK,
	input logic wbEnable,
	input idPkg::regAddr_t wbReg,
	input idPkg::word_t wbData,
	regReadIf.file rd
);
	import idPkg::*;

	word_t regs [32];

	// r0 is never stored
	always_ff @(posedge CLK) begin
		if (wbEnable && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	// reads are combinational, no write-through
	assign rd.rsData = (rd.rsAddr == '0) ? '0 : regs[rd.rsAddr];
	assign rd.rtData = (rd.rtAddr == '0) ? '0 : regs[rd.rtAddr];
	assign rd.destData = (rd.destAddr == '0) ? '0 : regs[rd.destAddr];
	assign rd.sysData = regs[SYSCALL_REG];

endmodule

//--- source/branchResolve.sv
`timescale 1ns/1ps

module branchResolve (
	input idPkg::word_t instr,
	input idPkg::word_t pcPlus4,
	regReadIf.reader rd,
	output logic takenBranch,
	output idPkg::word_t nextAddress
);
	import idPkg::*;

	opcode_t opcode;
	funct_t funct;
	regAddr_t rtField;
	word_t branchTarget;
	word_t jumpTarget;
	word_t jumpAddr;
	logic isJump;
	logic condMet;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rtField = instr[20:16];

	// word offset relative to the delay slot
	assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

	always_comb begin
		isJump = 1'b0;
		condMet = 1'b0;
		jumpAddr = jumpTarget;
		case (opcode)
			OP_J, OP_JAL: isJump = 1'b1;
			OP_SPECIAL: begin
				if (funct == FN_JR || funct == FN_JALR) begin
					isJump = 1'b1;
					jumpAddr = rd.rsData;
				end
			end
			OP_BEQ: condMet = (rd.rsData == rd.rtData);
			OP_BNE: condMet = (rd.rsData != rd.rtData);
			OP_BLEZ: condMet = ($signed(rd.rsData) <= 0);
			OP_BGTZ: condMet = ($signed(rd.rsData) > 0);
			OP_REGIMM: begin
				// link variants share the plain conditions
				case (rtField)
					RT_BLTZ, RT_BLTZAL: condMet = rd.rsData[31];
					RT_BGEZ, RT_BGEZAL: condMet = !rd.rsData[31];
					default: condMet = 1'b0;
				endcase
			end
			default: condMet = 1'b0;
		endcase
	end

	assign takenBranch = isJump | condMet;
	assign nextAddress = isJump ? jumpAddr : (condMet ? branchTarget : pcPlus4);

endmodule

//--- source/idPipeReg.sv
`timescale 1ns/1ps

module idPipeReg (
	input logic CLK,
	input logic RESET,
	input logic freeze,
	input logic bubble,
	input idPkg::word_t instr,
	input idPkg::word_t pcPlus4,
	input logic takenBranch,
	ctrlIf.pipe ctrl,
	regReadIf.pipe rd,
	output idPkg::word_t operandA,
	output idPkg::word_t operandB,
	output idPkg::word_t destValue,
	output idPkg::word_t storeData,
	output idPkg::word_t instrOut,
	output idPkg::regAddr_t writeRegOut,
	output idPkg::regAddr_t readRegA,
	output idPkg::regAddr_t readRegB,
	output idPkg::regAddr_t shamt,
	output idPkg::aluOp_t aluOp,
	output logic aluSrc,
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic doWriteback,
	output logic takenBranchOut,
	output logic sysOut,
	output logic illegal
);
	import idPkg::*;

	typedef struct packed {
		word_t operandA;
		word_t operandB;
		word_t destValue;
		word_t storeData;
		word_t instr;
		regAddr_t writeReg;
		regAddr_t readRegA;
		regAddr_t readRegB;
		regAddr_t shamt;
		aluOp_t aluOp;
		logic aluSrc;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic doWriteback;
		logic takenBranch;
		logic sysOut;
		logic illegal;
	} idEx_t;

	regAddr_t writeReg;
	idEx_t nextQ;
	idEx_t pipeQ;

	assign writeReg = ctrl.regDst ? instr[15:11] :
		(ctrl.link ? LINK_REG : (ctrl.syscall ? '0 : instr[20:16]));
	assign rd.destAddr = writeReg;

	always_comb begin
		nextQ.operandA = ctrl.link ? pcPlus4 : (ctrl.syscall ? rd.sysData : rd.rsData);
		nextQ.operandB = ctrl.link ? LINK_OFFSET : (ctrl.syscall ? '0 : rd.rtData);
		nextQ.destValue = rd.destData;
		nextQ.storeData = rd.rtData;
		nextQ.instr = instr;
		nextQ.writeReg = writeReg;
		nextQ.readRegA = (ctrl.link || ctrl.syscall) ? '0 : instr[25:21];
		nextQ.readRegB = (ctrl.aluSrc || ctrl.link || ctrl.syscall) ? '0 : instr[20:16];
		nextQ.shamt = instr[10:6];
		nextQ.aluOp = ctrl.aluOp;
		nextQ.aluSrc = ctrl.aluSrc;
		nextQ.memRead = ctrl.memRead;
		nextQ.memWrite = ctrl.memWrite;
		nextQ.memToReg = ctrl.memToReg;
		nextQ.doWriteback = ctrl.regWrite;
		// only control-flow instructions redirect fetch
		nextQ.takenBranch = takenBranch & (ctrl.jump | ctrl.jumpReg | ctrl.branch);
		nextQ.sysOut = ctrl.syscall;
		nextQ.illegal = ctrl.illegal;
	end

	// bubble wins over freeze
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			pipeQ <= '0;
		end else if (bubble) begin
			pipeQ <= '0;
		end else if (!freeze) begin
			pipeQ <= nextQ;
		end
	end

	assign operandA = pipeQ.operandA;
	assign operandB = pipeQ.operandB;
	assign destValue = pipeQ.destValue;
	assign storeData = pipeQ.storeData;
	assign instrOut = pipeQ.instr;
	assign writeRegOut = pipeQ.writeReg;
	assign readRegA = pipeQ.readRegA;
	assign readRegB = pipeQ.readRegB;
	assign shamt = pipeQ.shamt;
	assign aluOp = pipeQ.aluOp;
	assign aluSrc = pipeQ.aluSrc;
	assign memRead = pipeQ.memRead;
	assign memWrite = pipeQ.memWrite;
	assign memToReg = pipeQ.memToReg;
	assign doWriteback = pipeQ.doWriteback;
	assign takenBranchOut = pipeQ.takenBranch;
	assign sysOut = pipeQ.sysOut;
	assign illegal = pipeQ.illegal;

endmodule

//--- source/idTop.sv
`timescale 1ns/1ps

module idTop (
	input logic CLK,
	input logic RESET,
	input idPkg::word_t instr,
	input idPkg::word_t pcPlus4,
	input logic wbEnable,
	input idPkg::regAddr_t wbReg,
	input idPkg::word_t wbData,
	input logic freeze,
	input logic bubble,
	output idPkg::word_t operandA,
	output idPkg::word_t operandB,
	output idPkg::word_t destValue,
	output idPkg::word_t storeData,
	output idPkg::word_t instrOut,
	output idPkg::regAddr_t writeRegOut,
	output idPkg::regAddr_t readRegA,
	output idPkg::regAddr_t readRegB,
	output idPkg::regAddr_t shamt,
	output idPkg::aluOp_t aluOp,
	output logic aluSrc,
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic doWriteback,
	output logic takenBranchOut,
	output logic sysOut,
	output logic illegal,
	output idPkg::word_t nextAddress
);

	logic takenBranch;

	ctrlIf ctrlBus ();
	regReadIf regBus ();

	// source register fields
	assign regBus.rsAddr = instr[25:21];
	assign regBus.rtAddr = instr[20:16];

	controlDecoder decoder_i (
		.instr(instr),
		.ctrl(ctrlBus)
	);

	registerFile regFile_i (
		.CLK(CLK),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData),
		.rd(regBus)
	);

	branchResolve branch_i (
		.instr(instr),
		.pcPlus4(pcPlus4),
		.rd(regBus),
		.takenBranch(takenBranch),
		.nextAddress(nextAddress)
	);

	idPipeReg pipe_i (
		.CLK(CLK),
		.RESET(RESET),
		.freeze(freeze),
		.bubble(bubble),
		.instr(instr),
		.pcPlus4(pcPlus4),
		.takenBranch(takenBranch),
		.ctrl(ctrlBus),
		.rd(regBus),
		.operandA(operandA),
		.operandB(operandB),
		.destValue(destValue),
		.storeData(storeData),
		.instrOut(instrOut),
		.writeRegOut(writeRegOut),
		.readRegA(readRegA),
		.readRegB(readRegB),
		.shamt(shamt),
		.aluOp(aluOp),
		.aluSrc(aluSrc),
		.memRead(memRead),
		.memWrite(memWrite),
		.memToReg(memToReg),
		.doWriteback(doWriteback),
		.takenBranchOut(takenBranchOut),
		.sysOut(sysOut),
		.illegal(illegal)
	);

endmodule

//--- sim/idPipe_assert.sv
`timescale 1ns/1ps

module idPipeAssert (
	input logic CLK,
	input logic RESET,
	input logic freeze,
	input logic bubble,
	input idPkg::word_t operandA,
	input logic memRead,
	input logic memWrite,
	input logic doWriteback
);

	// a bubble leaves no write behind
	bubbleClears: assert property (@(posedge CLK) disable iff (!RESET)
		bubble |=> (!doWriteback && !memWrite))
		else $error("doWriteback or memWrite still set in the cycle after a bubble");

	holdOnFreeze: assert property (@(posedge CLK) disable iff (!RESET)
		(freeze && !bubble) |=> $stable(operandA))
		else $error("operandA changed while the stage was frozen");

	noReadAndWrite: assert property (@(posedge CLK) disable iff (!RESET)
		!(memRead && memWrite))
		else $error("memRead and memWrite were high in the same cycle");

endmodule

bind idPipeReg idPipeAssert pipeChecks_i (
	.CLK(CLK),
	.RESET(RESET),
	.freeze(freeze),
	.bubble(bubble),
	.operandA(operandA),
	.memRead(memRead),
	.memWrite(memWrite),
	.doWriteback(doWriteback)
);

//--- sim/idTb.sv
`timescale 1ns/1ps

module idTb;
	import idPkg::*;

	localparam int PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int LOAD_CYCLES = 36;
	localparam int CYCLES_PER_ENTRY = 1;

	localparam word_t PC = 32'h0040_0010;
	localparam word_t JPC = 32'h9000_0010;
	// bit order src, memRd, memWr, toReg, wb, link, sys, ill
	localparam logic [7:0] R_CTRL = 8'b0000_1000;
	localparam logic [7:0] I_CTRL = 8'b1000_1000;
	localparam logic [7:0] LD_CTRL = 8'b1101_1000;
	localparam logic [7:0] ST_CTRL = 8'b1010_0000;
	localparam logic [7:0] BR_CTRL = 8'b0000_0000;
	localparam logic [7:0] LINK_CTRL = 8'b1000_1100;
	localparam logic [7:0] SYS_CTRL = 8'b1000_1010;
	localparam logic [7:0] ILL_CTRL = 8'b0000_0001;

	typedef struct {
		string name;
		word_t instr;
		word_t pc;
		logic frz;
		logic bub;
		aluOp_t op;
		logic src;
		logic memRd;
		logic memWr;
		logic toReg;
		logic wb;
		logic link;
		logic sys;
		logic ill;
		regAddr_t dest;
		logic taken;
		word_t next;
	} entry_t;

	typedef struct packed {
		word_t operandA;
		word_t operandB;
		word_t destValue;
		word_t storeData;
		word_t instrOut;
		regAddr_t writeReg;
		regAddr_t readRegA;
		regAddr_t readRegB;
		regAddr_t shamt;
		aluOp_t aluOp;
		logic aluSrc;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic doWriteback;
		logic taken;
		logic sysOut;
		logic illegal;
	} out_t;

	logic CLK;
	logic RESET;
	word_t instr;
	word_t pcPlus4;
	logic wbEnable;
	regAddr_t wbReg;
	word_t wbData;
	logic freeze;
	logic bubble;
	word_t operandA;
	word_t operandB;
	word_t destValue;
	word_t storeData;
	word_t instrOut;
	regAddr_t writeRegOut;
	regAddr_t readRegA;
	regAddr_t readRegB;
	regAddr_t shamt;
	aluOp_t aluOp;
	logic aluSrc;
	logic memRead;
	logic memWrite;
	logic memToReg;
	logic doWriteback;
	logic takenBranchOut;
	logic sysOut;
	logic illegal;
	word_t nextAddress;

	integer seed;
	word_t model [32];
	entry_t tests [$];
	logic tableReady;

	idTop dut_i (
		.CLK(CLK),
		.RESET(RESET),
		.instr(instr),
		.pcPlus4(pcPlus4),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData),
		.freeze(freeze),
		.bubble(bubble),
		.operandA(operandA),
		.operandB(operandB),
		.destValue(destValue),
		.storeData(storeData),
		.instrOut(instrOut),
		.writeRegOut(writeRegOut),
		.readRegA(readRegA),
		.readRegB(readRegB),
		.shamt(shamt),
		.aluOp(aluOp),
		.aluSrc(aluSrc),
		.memRead(memRead),
		.memWrite(memWrite),
		.memToReg(memToReg),
		.doWriteback(doWriteback),
		.takenBranchOut(takenBranchOut),
		.sysOut(sysOut),
		.illegal(illegal),
		.nextAddress(nextAddress)
	);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	task automatic reportFailure(input string why);
		$display("Something failed");
		$fatal(1, "%s", why);
	endtask

	task automatic checkWord(input string name, input string what, input word_t exp,
			input word_t act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %h, actual %h", name, what, exp, act);
			reportFailure("output value mismatch");
		end
	endtask

	task automatic checkReg(input string name, input string what, input regAddr_t exp,
			input regAddr_t act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %0d, actual %0d", name, what, exp, act);
			reportFailure("register index mismatch");
		end
	endtask

	task automatic checkAluOp(input string name, input aluOp_t exp, input aluOp_t act);
		if (act !== exp) begin
			$display("ERR %s aluOp: expected %s (%0d), actual %s (%0d)", name,
				exp.name(), exp, act.name(), act);
			reportFailure("ALU operation mismatch");
		end
	endtask

	task automatic checkBit(input string name, input string what, input logic exp,
			input logic act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %b, actual %b", name, what, exp, act);
			reportFailure("control bit mismatch");
		end
	endtask

	// MIPS instruction formats
	function automatic word_t rType(input regAddr_t rs, input regAddr_t rt,
			input regAddr_t rd, input regAddr_t sh, input funct_t fn);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t iType(input opcode_t op, input regAddr_t rs,
			input regAddr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jType(input opcode_t op, input logic [25:0] target);
		return {op, target};
	endfunction

	task automatic addEntry(input string name, input word_t ins, input word_t pc,
			input logic [1:0] fb, input aluOp_t op, input logic [7:0] bits,
			input regAddr_t dest, input logic taken, input word_t next);
		entry_t e;
		e.name = name;
		e.instr = ins;
		e.pc = pc;
		{e.frz, e.bub} = fb;
		e.op = op;
		{e.src, e.memRd, e.memWr, e.toReg, e.wb, e.link, e.sys, e.ill} = bits;
		e.dest = dest;
		e.taken = taken;
		e.next = next;
		tests.push_back(e);
	endtask

	task automatic buildTable();
		regAddr_t rs;
		regAddr_t rt;
		// each register read once and r31 pairs with r0
		for (int k = 1; k < 32; k += 2) begin
			rs = regAddr_t'(k);
			rt = regAddr_t'(k + 1);
			addEntry($sformatf("read r%0d r%0d", rs, rt), rType(rs, rt, rs, 5'd0, FN_ADDU),
				PC, 2'b00, ADDU, R_CTRL, rs, 1'b0, PC);
		end
		addEntry("sll", rType(5'd0, 5'd5, 5'd6, 5'd7, FN_SLL), PC, 2'b00, SLL, R_CTRL,
			5'd6, 1'b0, PC);
		addEntry("srl", rType(5'd0, 5'd8, 5'd9, 5'd31, FN_SRL), PC, 2'b00, SRL, R_CTRL,
			5'd9, 1'b0, PC);
		addEntry("sra", rType(5'd0, 5'd3, 5'd4, 5'd12, FN_SRA), PC, 2'b00, SRA, R_CTRL,
			5'd4, 1'b0, PC);
		addEntry("sllv", rType(5'd1, 5'd2, 5'd3, 5'd0, FN_SLLV), PC, 2'b00, SLLV, R_CTRL,
			5'd3, 1'b0, PC);
		addEntry("srlv", rType(5'd4, 5'd5, 5'd6, 5'd0, FN_SRLV), PC, 2'b00, SRLV, R_CTRL,
			5'd6, 1'b0, PC);
		addEntry("srav", rType(5'd7, 5'd8, 5'd9, 5'd0, FN_SRAV), PC, 2'b00, SRAV, R_CTRL,
			5'd9, 1'b0, PC);
		addEntry("add", rType(5'd10, 5'd11, 5'd12, 5'd0, FN_ADD), PC, 2'b00, ADD, R_CTRL,
			5'd12, 1'b0, PC);
		addEntry("sub", rType(5'd13, 5'd14, 5'd15, 5'd0, FN_SUB), PC, 2'b00, SUB, R_CTRL,
			5'd15, 1'b0, PC);
		addEntry("subu", rType(5'd20, 5'd21, 5'd22, 5'd0, FN_SUBU), PC, 2'b00, SUBU, R_CTRL,
			5'd22, 1'b0, PC);
		addEntry("and", rType(5'd23, 5'd24, 5'd25, 5'd0, FN_AND), PC, 2'b00, AND, R_CTRL,
			5'd25, 1'b0, PC);
		addEntry("or", rType(5'd26, 5'd27, 5'd28, 5'd0, FN_OR), PC, 2'b00, OR, R_CTRL,
			5'd28, 1'b0, PC);
		addEntry("xor", rType(5'd29, 5'd30, 5'd1, 5'd0, FN_XOR), PC, 2'b00, XOR, R_CTRL,
			5'd1, 1'b0, PC);
		addEntry("nor", rType(5'd2, 5'd3, 5'd4, 5'd0, FN_NOR), PC, 2'b00, NOR, R_CTRL,
			5'd4, 1'b0, PC);
		addEntry("slt", rType(5'd5, 5'd6, 5'd7, 5'd0, FN_SLT), PC, 2'b00, SLT, R_CTRL,
			5'd7, 1'b0, PC);
		addEntry("sltu", rType(5'd8, 5'd9, 5'd10, 5'd0, FN_SLTU), PC, 2'b00, SLTU, R_CTRL,
			5'd10, 1'b0, PC);
		addEntry("addi", iType(OP_ADDI, 5'd1, 5'd4, 16'h8001), PC, 2'b00, ADDI, I_CTRL,
			5'd4, 1'b0, PC);
		addEntry("addiu", iType(OP_ADDIU, 5'd2, 5'd5, 16'h0010), PC, 2'b00, ADDIU, I_CTRL,
			5'd5, 1'b0, PC);
		addEntry("slti", iType(OP_SLTI, 5'd3, 5'd6, 16'hffff), PC, 2'b00, SLT, I_CTRL,
			5'd6, 1'b0, PC);
		addEntry("sltiu", iType(OP_SLTIU, 5'd4, 5'd7, 16'h0100), PC, 2'b00, SLTU, I_CTRL,
			5'd7, 1'b0, PC);
		addEntry("andi", iType(OP_ANDI, 5'd5, 5'd8, 16'h00ff), PC, 2'b00, ANDI, I_CTRL,
			5'd8, 1'b0, PC);
		addEntry("ori", iType(OP_ORI, 5'd6, 5'd9, 16'hf0f0), PC, 2'b00, ORI, I_CTRL,
			5'd9, 1'b0, PC);
		addEntry("xori", iType(OP_XORI, 5'd7, 5'd10, 16'h5555), PC, 2'b00, XORI, I_CTRL,
			5'd10, 1'b0, PC);
		addEntry("lui", iType(OP_LUI, 5'd0, 5'd11, 16'h1234), PC, 2'b00, LUI, I_CTRL,
			5'd11, 1'b0, PC);
		addEntry("lw", iType(OP_LW, 5'd3, 5'd8, 16'h0010), PC, 2'b00, LW, LD_CTRL,
			5'd8, 1'b0, PC);
		addEntry("lb", iType(OP_LB, 5'd4, 5'd9, 16'hfff0), PC, 2'b00, LB, LD_CTRL,
			5'd9, 1'b0, PC);
		addEntry("lh", iType(OP_LH, 5'd5, 5'd10, 16'h0002), PC, 2'b00, LH, LD_CTRL,
			5'd10, 1'b0, PC);
		addEntry("lbu", iType(OP_LBU, 5'd6, 5'd11, 16'h0003), PC, 2'b00, LBU, LD_CTRL,
			5'd11, 1'b0, PC);
		addEntry("lhu", iType(OP_LHU, 5'd7, 5'd12, 16'h0006), PC, 2'b00, LHU, LD_CTRL,
			5'd12, 1'b0, PC);
		addEntry("sw", iType(OP_SW, 5'd8, 5'd13, 16'h0020), PC, 2'b00, SW, ST_CTRL,
			5'd13, 1'b0, PC);
		addEntry("sh", iType(OP_SH, 5'd9, 5'd14, 16'h0022), PC, 2'b00, SH, ST_CTRL,
			5'd14, 1'b0, PC);
		addEntry("sb", iType(OP_SB, 5'd10, 5'd15, 16'h0023), PC, 2'b00, SB, ST_CTRL,
			5'd15, 1'b0, PC);
		// r16 and r18 hold 5 and r17 is negative
		addEntry("beq taken", iType(OP_BEQ, 5'd16, 5'd18, 16'h0004), PC, 2'b00, BEQ, BR_CTRL,
			5'd18, 1'b1, 32'h0040_0020);
		addEntry("beq not", iType(OP_BEQ, 5'd16, 5'd17, 16'h0004), PC, 2'b00, BEQ, BR_CTRL,
			5'd17, 1'b0, PC);
		addEntry("bne taken", iType(OP_BNE, 5'd16, 5'd17, 16'hfffc), PC, 2'b00, BNE, BR_CTRL,
			5'd17, 1'b1, 32'h0040_0000);
		addEntry("bne not", iType(OP_BNE, 5'd16, 5'd18, 16'hfffc), PC, 2'b00, BNE, BR_CTRL,
			5'd18, 1'b0, PC);
		addEntry("blez neg", iType(OP_BLEZ, 5'd17, 5'd0, 16'h0004), PC, 2'b00, BLEZ, BR_CTRL,
			5'd0, 1'b1, 32'h0040_0020);
		addEntry("blez zero", iType(OP_BLEZ, 5'd0, 5'd0, 16'h0004), PC, 2'b00, BLEZ, BR_CTRL,
			5'd0, 1'b1, 32'h0040_0020);
		addEntry("blez not", iType(OP_BLEZ, 5'd16, 5'd0, 16'h0004), PC, 2'b00, BLEZ, BR_CTRL,
			5'd0, 1'b0, PC);
		addEntry("bgtz taken", iType(OP_BGTZ, 5'd16, 5'd0, 16'hfffc), PC, 2'b00, BGTZ, BR_CTRL,
			5'd0, 1'b1, 32'h0040_0000);
		addEntry("bgtz not", iType(OP_BGTZ, 5'd17, 5'd0, 16'hfffc), PC, 2'b00, BGTZ, BR_CTRL,
			5'd0, 1'b0, PC);
		addEntry("bltz taken", iType(OP_REGIMM, 5'd17, RT_BLTZ, 16'h0004), PC, 2'b00, BLTZ, BR_CTRL,
			RT_BLTZ, 1'b1, 32'h0040_0020);
		addEntry("bltz not", iType(OP_REGIMM, 5'd16, RT_BLTZ, 16'h0004), PC, 2'b00, BLTZ, BR_CTRL,
			RT_BLTZ, 1'b0, PC);
		addEntry("bgez taken", iType(OP_REGIMM, 5'd0, RT_BGEZ, 16'h0004), PC, 2'b00, BGEZ, BR_CTRL,
			RT_BGEZ, 1'b1, 32'h0040_0020);
		addEntry("bgez not", iType(OP_REGIMM, 5'd17, RT_BGEZ, 16'h0004), PC, 2'b00, BGEZ, BR_CTRL,
			RT_BGEZ, 1'b0, PC);
		addEntry("bltzal taken", iType(OP_REGIMM, 5'd17, RT_BLTZAL, 16'h0004), PC, 2'b00, ADDI,
			LINK_CTRL, LINK_REG, 1'b1, 32'h0040_0020);
		addEntry("bltzal not", iType(OP_REGIMM, 5'd16, RT_BLTZAL, 16'h0004), PC, 2'b00, ADDI,
			LINK_CTRL, LINK_REG, 1'b0, PC);
		addEntry("bgezal taken", iType(OP_REGIMM, 5'd16, RT_BGEZAL, 16'hfffc), PC, 2'b00, ADDI,
			LINK_CTRL, LINK_REG, 1'b1, 32'h0040_0000);
		addEntry("bgezal not", iType(OP_REGIMM, 5'd17, RT_BGEZAL, 16'hfffc), PC, 2'b00, ADDI,
			LINK_CTRL, LINK_REG, 1'b0, PC);
		addEntry("j", jType(OP_J, 26'h000_0040), JPC, 2'b00, J, BR_CTRL, 5'd0,
			1'b1, 32'h9000_0100);
		addEntry("jal", jType(OP_JAL, 26'h000_0040), JPC, 2'b00, ADDI, LINK_CTRL, LINK_REG,
			1'b1, 32'h9000_0100);
		// r19 holds the register jump target
		addEntry("jr", rType(5'd19, 5'd0, 5'd0, 5'd0, FN_JR), PC, 2'b00, JR, BR_CTRL, 5'd0,
			1'b1, 32'h0040_0100);
		addEntry("jalr", rType(5'd19, 5'd0, 5'd31, 5'd0, FN_JALR), PC, 2'b00, ADDI, LINK_CTRL,
			LINK_REG, 1'b1, 32'h0040_0100);
		addEntry("syscall", rType(5'd0, 5'd0, 5'd0, 5'd0, FN_SYSCALL), PC, 2'b00, ADDI, SYS_CTRL,
			5'd0, 1'b0, PC);
		addEntry("bad opcode", iType(6'h3f, 5'd0, 5'd0, 16'h0000), PC, 2'b00, ADD, ILL_CTRL,
			5'd0, 1'b0, PC);
		addEntry("bad funct", rType(5'd1, 5'd2, 5'd3, 5'd0, 6'h3f), PC, 2'b00, ADD, ILL_CTRL,
			5'd2, 1'b0, PC);
		addEntry("before freeze", rType(5'd3, 5'd4, 5'd5, 5'd9, FN_SUB), PC, 2'b00, SUB, R_CTRL,
			5'd5, 1'b0, PC);
		// frozen entries still resolve the branch combinationally
		addEntry("freeze hold", iType(OP_BEQ, 5'd16, 5'd18, 16'h0004), PC, 2'b10, BEQ, BR_CTRL,
			5'd18, 1'b1, 32'h0040_0020);
		addEntry("freeze again", iType(OP_LW, 5'd1, 5'd2, 16'h0004), PC, 2'b10, LW, LD_CTRL,
			5'd2, 1'b0, PC);
		addEntry("after freeze", rType(5'd6, 5'd7, 5'd8, 5'd0, FN_AND), PC, 2'b00, AND, R_CTRL,
			5'd8, 1'b0, PC);
		// bubble over a live bundle so a held value would show
		addEntry("bubble and freeze", iType(OP_SW, 5'd3, 5'd4, 16'h0008), PC, 2'b11, SW, ST_CTRL,
			5'd4, 1'b0, PC);
		addEntry("after bubble", rType(5'd9, 5'd10, 5'd11, 5'd0, FN_OR), PC, 2'b00, OR, R_CTRL,
			5'd11, 1'b0, PC);
		addEntry("bubble clear", iType(OP_LW, 5'd1, 5'd2, 16'h0004), PC, 2'b01, LW, LD_CTRL,
			5'd2, 1'b0, PC);
	endtask

	// expected ID/EX bundle from the decode rules and the register model
	function automatic out_t predict(input entry_t e);
		out_t r;
		regAddr_t rs;
		regAddr_t rt;
		rs = e.instr[25:21];
		rt = e.instr[20:16];
		r.operandA = e.link ? e.pc : (e.sys ? model[SYSCALL_REG] : model[rs]);
		r.operandB = e.link ? LINK_OFFSET : (e.sys ? '0 : model[rt]);
		r.destValue = model[e.dest];
		r.storeData = model[rt];
		r.instrOut = e.instr;
		r.writeReg = e.dest;
		r.readRegA = (e.link || e.sys) ? '0 : rs;
		r.readRegB = (e.src || e.link || e.sys) ? '0 : rt;
		r.shamt = e.instr[10:6];
		r.aluOp = e.op;
		r.aluSrc = e.src;
		r.memRead = e.memRd;
		r.memWrite = e.memWr;
		r.memToReg = e.toReg;
		r.doWriteback = e.wb;
		r.taken = e.taken;
		r.sysOut = e.sys;
		r.illegal = e.ill;
		return r;
	endfunction

	task automatic checkOutputs(input string name, input out_t exp);
		checkWord(name, "operandA", exp.operandA, operandA);
		checkWord(name, "operandB", exp.operandB, operandB);
		checkWord(name, "destValue", exp.destValue, destValue);
		checkWord(name, "storeData", exp.storeData, storeData);
		checkWord(name, "instrOut", exp.instrOut, instrOut);
		checkReg(name, "writeRegOut", exp.writeReg, writeRegOut);
		checkReg(name, "readRegA", exp.readRegA, readRegA);
		checkReg(name, "readRegB", exp.readRegB, readRegB);
		checkReg(name, "shamt", exp.shamt, shamt);
		checkAluOp(name, exp.aluOp, aluOp);
		checkBit(name, "aluSrc", exp.aluSrc, aluSrc);
		checkBit(name, "memRead", exp.memRead, memRead);
		checkBit(name, "memWrite", exp.memWrite, memWrite);
		checkBit(name, "memToReg", exp.memToReg, memToReg);
		checkBit(name, "doWriteback", exp.doWriteback, doWriteback);
		checkBit(name, "takenBranchOut", exp.taken, takenBranchOut);
		checkBit(name, "sysOut", exp.sysOut, sysOut);
		checkBit(name, "illegal", exp.illegal, illegal);
	endtask

	// starts on a falling edge and ends on the next one
	task automatic writeRegister(input regAddr_t addr, input word_t data);
		wbEnable = 1'b1;
		wbReg = addr;
		wbData = data;
		if (addr != '0) begin
			model[addr] = data;
		end
		@(negedge CLK);
	endtask

	task automatic loadRegisters();
		word_t value;
		model[0] = '0;
		for (int r = 0; r < 32; r++) begin
			value = $random(seed);
			writeRegister(regAddr_t'(r), value);
		end
		writeRegister(5'd16, 32'h0000_0005);
		writeRegister(5'd17, 32'hffff_fff0);
		writeRegister(5'd18, 32'h0000_0005);
		writeRegister(5'd19, 32'h0040_0100);
		wbEnable = 1'b0;
	endtask

	initial begin : watchdog
		int limit;
		wait (tableReady);
		limit = (RESET_CYCLES + LOAD_CYCLES + tests.size() * CYCLES_PER_ENTRY + 10) * PERIOD;
		#(limit);
		reportFailure($sformatf("watchdog expired after %0d ns, the run did not finish", limit));
	end

	initial begin : stimulus
		out_t expected;
		out_t held;
		RESET = 1'b0;
		instr = '0;
		pcPlus4 = '0;
		wbEnable = 1'b0;
		wbReg = '0;
		wbData = '0;
		freeze = 1'b0;
		bubble = 1'b0;
		seed = 32'h443c6bdb;
		tableReady = 1'b0;
		buildTable();
		tableReady = 1'b1;
		repeat (RESET_CYCLES) @(negedge CLK);
		checkBit("reset", "doWriteback", 1'b0, doWriteback);
		checkBit("reset", "memRead", 1'b0, memRead);
		checkBit("reset", "memWrite", 1'b0, memWrite);
		checkBit("reset", "memToReg", 1'b0, memToReg);
		checkBit("reset", "takenBranchOut", 1'b0, takenBranchOut);
		checkBit("reset", "sysOut", 1'b0, sysOut);
		checkBit("reset", "illegal", 1'b0, illegal);
		RESET = 1'b1;
		loadRegisters();
		held = '0;
		foreach (tests[i]) begin
			instr = tests[i].instr;
			pcPlus4 = tests[i].pc;
			freeze = tests[i].frz;
			bubble = tests[i].bub;
			#(PERIOD / 4);
			checkWord(tests[i].name, "nextAddress", tests[i].next, nextAddress);
			expected = predict(tests[i]);
			// bubble wins over freeze
			if (tests[i].bub) begin
				expected = '0;
			end else if (tests[i].frz) begin
				expected = held;
			end
			@(negedge CLK);
			checkOutputs(tests[i].name, expected);
			held = expected;
		end
		$display("Everything OK");
		$finish;
	end

endmodule

//--- build.f
source/idPkg.sv
source/ctrlIf.sv
source/regReadIf.sv
source/controlDecoder.sv
source/registerFile.sv
source/branchResolve.sv
source/idPipeReg.sv
source/idTop.sv
sim/idPipe_assert.sv
sim/idTb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the ID stage testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module idTb -Mdir obj_dir -f build.f
	./obj_dir/VidTb

clean:
	rm -rf obj_dir
